//--- usb_rx_config.svh
// USB receive path constants

`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

////////////////////
// Bit timing
////////////////////

// Full speed samples when these low DPLL counter bits are all ones
`define USB_FS_SAMPLE_MASK_BITS 2

// Low speed sample point, counted from the last transition (32-cycle bit)
`define USB_LS_SAMPLE_POINT 13

// EOP state machine runs this much slower at low speed
`define USB_LS_EOP_DIVIDE 8

////////////////////
// Sync search and queue
////////////////////

// Cycles the sync finder may linger in one state
`define USB_FS_SYNC_TIMEOUT 7
`define USB_LS_SYNC_TIMEOUT 63

// Entries in the receive event queue
`define USB_RX_QUEUE_DEPTH 4

`endif

//--- usb_rx_pkg.sv
// USB receive path types

`default_nettype none

package usb_rx_pkg;

	// EOP detector, counts SE0 ticks then looks for J
	typedef enum logic [2:0] {
		EOP_IDLE,
		EOP_SE0_1,
		EOP_SE0_2,
		EOP_SE0_3,
		EOP_J_WAIT
	} eop_state_e;

	// Sync finder walks KJKJKJ then wants two sampled K bits
	typedef enum logic [3:0] {
		SYNC_IDLE,
		SYNC_K1,
		SYNC_J1,
		SYNC_K2,
		SYNC_J2,
		SYNC_K3,
		SYNC_J3,
		SYNC_K4,
		SYNC_K5
	} sync_state_e;

	// Four-phase handshake at the queue output
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_REQ,
		HS_RELEASE
	} hs_state_e;

	typedef enum logic [1:0] {
		EVT_DATA,
		EVT_EOP,
		EVT_ERROR
	} rx_event_kind_e;

	// Data is zero for anything but EVT_DATA
	typedef struct packed {
		rx_event_kind_e kind;
		logic [7:0]     data;
	} rx_event_t;

endpackage

`default_nettype wire

//--- usb_line_sampler.sv
// USB line sampler and DPLL

`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_line_sampler (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rx,
	input  logic low_speed,
	output logic rx_level,
	output logic sample
);

	localparam int CNT_W = 5;
	localparam int FS_BITS = `USB_FS_SAMPLE_MASK_BITS;

	logic             rx_r;
	logic             transition;
	logic [CNT_W-1:0] dpll_cnt;
	logic             ls_point;
	logic             fs_point;

	// Low speed idles with J at the opposite level
	assign rx_level = rx ^ low_speed;

	always_ff @(posedge usb_clk) begin
		rx_r <= rx;
	end

	assign transition = rx != rx_r;
	assign ls_point = dpll_cnt == CNT_W'(`USB_LS_SAMPLE_POINT);
	assign fs_point = &dpll_cnt[FS_BITS-1:0];

	// Counter realigns on every edge of the line
	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			dpll_cnt <= '0;
			sample <= 1'b0;
		end else begin
			if (transition)
				dpll_cnt <= '0;
			else
				dpll_cnt <= dpll_cnt + 1'b1;
			sample <= low_speed ? ls_point : (transition | fs_point);
		end
	end

endmodule

`default_nettype wire

//--- usb_eop_detect.sv
// USB end-of-packet detector

`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_eop_detect (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rxp,
	input  logic rxm,
	input  logic rx_level,
	input  logic low_speed,
	output logic eop
);

	localparam int DIV_W = $clog2(`USB_LS_EOP_DIVIDE);

	usb_rx_pkg::eop_state_e state;
	usb_rx_pkg::eop_state_e next_state;
	logic [DIV_W-1:0]       div_cnt;
	logic                   tick;
	logic                   se0;
	logic                   eop_hit;

	assign se0 = ~rxp & ~rxm;

	// Slow tick for low speed, every cycle at full speed
	always_ff @(posedge usb_clk) begin
		if (rxreset)
			div_cnt <= '0;
		else if (div_cnt == DIV_W'(`USB_LS_EOP_DIVIDE - 1))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign tick = ~low_speed | (div_cnt == '0);

	always_ff @(posedge usb_clk) begin
		if (rxreset)
			state <= usb_rx_pkg::EOP_IDLE;
		else if (tick)
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		eop_hit = 1'b0;
		case (state)
			usb_rx_pkg::EOP_IDLE:
				next_state = se0 ? usb_rx_pkg::EOP_SE0_1 : usb_rx_pkg::EOP_IDLE;
			usb_rx_pkg::EOP_SE0_1:
				next_state = se0 ? usb_rx_pkg::EOP_SE0_2 : usb_rx_pkg::EOP_IDLE;
			usb_rx_pkg::EOP_SE0_2:
				next_state = se0 ? usb_rx_pkg::EOP_SE0_3 : usb_rx_pkg::EOP_IDLE;
			usb_rx_pkg::EOP_SE0_3: begin
				// Long enough SE0, now wait for J
				if (se0) begin
					next_state = usb_rx_pkg::EOP_SE0_3;
				end else if (rx_level) begin
					eop_hit = 1'b1;
					next_state = usb_rx_pkg::EOP_IDLE;
				end else begin
					next_state = usb_rx_pkg::EOP_J_WAIT;
				end
			end
			usb_rx_pkg::EOP_J_WAIT: begin
				// One tick of slack for a slow J
				eop_hit = rx_level;
				next_state = usb_rx_pkg::EOP_IDLE;
			end
			default:
				next_state = usb_rx_pkg::EOP_IDLE;
		endcase
	end

	assign eop = eop_hit & tick;

endmodule

`default_nettype wire

//--- usb_sync_detect.sv
// USB sync pattern finder

`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_sync_detect (
	input  logic usb_clk,
	input  logic rxreset,
	input  logic rx_level,
	input  logic sample,
	input  logic eop,
	input  logic active,
	input  logic low_speed,
	output logic start
);

	localparam int TMO_W = $clog2(`USB_LS_SYNC_TIMEOUT + 1);

	usb_rx_pkg::sync_state_e state;
	usb_rx_pkg::sync_state_e next_state;
	logic [TMO_W-1:0]        tmo_cnt;
	logic [TMO_W-1:0]        tmo_limit;
	logic                    timeout;

	////////////////////
	// Timeout
	////////////////////

	assign tmo_limit = low_speed ? TMO_W'(`USB_LS_SYNC_TIMEOUT)
	                             : TMO_W'(`USB_FS_SYNC_TIMEOUT);

	// Counts cycles spent in one state while searching
	always_ff @(posedge usb_clk) begin
		if (rxreset | eop) begin
			tmo_cnt <= '0;
			timeout <= 1'b0;
		end else begin
			if ((state != next_state) || (state == usb_rx_pkg::SYNC_IDLE))
				tmo_cnt <= '0;
			else
				tmo_cnt <= tmo_cnt + 1'b1;
			timeout <= tmo_cnt == tmo_limit;
		end
	end

	////////////////////
	// Pattern FSM
	////////////////////

	always_ff @(posedge usb_clk) begin
		if (rxreset | eop | timeout)
			state <= usb_rx_pkg::SYNC_IDLE;
		else
			state <= next_state;
	end

	// KJKJKJ follows line levels, the closing KK is sampled
	always_comb begin
		next_state = state;
		start = 1'b0;
		case (state)
			usb_rx_pkg::SYNC_IDLE:
				if (!rx_level && !active)
					next_state = usb_rx_pkg::SYNC_K1;
			usb_rx_pkg::SYNC_K1:
				if (rx_level)
					next_state = usb_rx_pkg::SYNC_J1;
			usb_rx_pkg::SYNC_J1:
				if (!rx_level)
					next_state = usb_rx_pkg::SYNC_K2;
			usb_rx_pkg::SYNC_K2:
				if (rx_level)
					next_state = usb_rx_pkg::SYNC_J2;
			usb_rx_pkg::SYNC_J2:
				if (!rx_level)
					next_state = usb_rx_pkg::SYNC_K3;
			usb_rx_pkg::SYNC_K3:
				if (rx_level)
					next_state = usb_rx_pkg::SYNC_J3;
			usb_rx_pkg::SYNC_J3:
				if (!rx_level)
					next_state = usb_rx_pkg::SYNC_K4;
			usb_rx_pkg::SYNC_K4:
				if (sample)
					next_state = rx_level ? usb_rx_pkg::SYNC_IDLE : usb_rx_pkg::SYNC_K5;
			usb_rx_pkg::SYNC_K5:
				if (sample) begin
					start = !rx_level;
					next_state = usb_rx_pkg::SYNC_IDLE;
				end
			default:
				next_state = usb_rx_pkg::SYNC_IDLE;
		endcase
	end

endmodule

`default_nettype wire

//--- usb_deserializer.sv
// USB NRZI decoder and deserializer

`timescale 1ns/10ps
`default_nettype none

module usb_deserializer (
	input  logic                  usb_clk,
	input  logic                  rxreset,
	input  logic                  rx_level,
	input  logic                  sample,
	input  logic                  eop,
	input  logic                  start,
	output logic                  active,
	output usb_rx_pkg::rx_event_t evt,
	output logic                  evt_valid
);

	logic [7:0] shift;
	logic [7:0] shift_next;
	logic [2:0] bit_cnt;
	logic [2:0] ones_cnt;
	logic       last_level;
	logic       data_bit;
	logic       take_bit;
	logic       stuff_bit;
	logic       stuff_err;
	logic       byte_done;
	logic       begin_rx;
	logic       eop_evt;

	////////////////////
	// Bit decode
	////////////////////

	// No transition means a one
	assign data_bit = ~(rx_level ^ last_level);
	assign shift_next = {data_bit, shift[7:1]};

	assign take_bit = sample & active & ~eop & (ones_cnt != 3'd6);
	assign stuff_bit = sample & active & ~eop & (ones_cnt == 3'd6);
	assign stuff_err = stuff_bit & (rx_level == last_level);
	assign byte_done = take_bit & (bit_cnt == 3'd7);
	assign begin_rx = start & ~active & ~eop;
	assign eop_evt = eop & active;

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			active <= 1'b0;
			evt_valid <= 1'b0;
			bit_cnt <= '0;
			ones_cnt <= '0;
			last_level <= 1'b0;
		end else begin
			evt_valid <= byte_done | stuff_err | eop_evt;
			if (eop | stuff_err)
				active <= 1'b0;
			else if (begin_rx)
				active <= 1'b1;

			if (begin_rx) begin
				// Sync ends on K with one trailing one
				bit_cnt <= '0;
				ones_cnt <= 3'd1;
				last_level <= 1'b0;
			end else if (take_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				ones_cnt <= data_bit ? ones_cnt + 1'b1 : 3'd0;
				last_level <= rx_level;
			end else if (stuff_bit) begin
				// Stuffed zero is dropped from the data
				ones_cnt <= '0;
				last_level <= rx_level;
			end
		end
	end

	always_ff @(posedge usb_clk) begin
		if (take_bit)
			shift <= shift_next;
		if (eop_evt)
			evt <= '{kind: usb_rx_pkg::EVT_EOP, data: 8'h00};
		else if (stuff_err)
			evt <= '{kind: usb_rx_pkg::EVT_ERROR, data: 8'h00};
		else if (byte_done)
			evt <= '{kind: usb_rx_pkg::EVT_DATA, data: shift_next};
	end

endmodule

`default_nettype wire

//--- usb_event_queue.sv
// USB receive event queue

`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_event_queue (
	input  logic                  usb_clk,
	input  logic                  rxreset,
	input  usb_rx_pkg::rx_event_t evt,
	input  logic                  evt_valid,
	output usb_rx_pkg::rx_event_t out_evt,
	output logic                  req,
	input  logic                  ack,
	output logic                  overrun
);

	localparam int DEPTH = `USB_RX_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	usb_rx_pkg::rx_event_t mem [DEPTH];
	usb_rx_pkg::hs_state_e hs_state;
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  full;
	logic                  push;
	logic                  pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = count == CNT_W'(DEPTH);
	assign push = evt_valid & ~full;
	assign pop = (hs_state == usb_rx_pkg::HS_REQ) & ack;
	assign req = hs_state == usb_rx_pkg::HS_REQ;

	// Head entry stays put until its handshake completes
	assign out_evt = mem[rd_ptr];

	always_ff @(posedge usb_clk) begin
		if (push)
			mem[wr_ptr] <= evt;
	end

	always_ff @(posedge usb_clk) begin
		if (rxreset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
			hs_state <= usb_rx_pkg::HS_IDLE;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(pop);
			if (evt_valid & full)
				overrun <= 1'b1;

			case (hs_state)
				usb_rx_pkg::HS_IDLE:
					if (!ack && ((count != '0) || push))
						hs_state <= usb_rx_pkg::HS_REQ;
				usb_rx_pkg::HS_REQ:
					if (ack)
						hs_state <= usb_rx_pkg::HS_RELEASE;
				usb_rx_pkg::HS_RELEASE:
					// Wait for the consumer to drop ack
					if (!ack)
						hs_state <= usb_rx_pkg::HS_IDLE;
				default:
					hs_state <= usb_rx_pkg::HS_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- usb_rx.sv
// USB receive path top level

`timescale 1ns/10ps
`default_nettype none

module usb_rx (
	input  logic                  usb_clk,
	input  logic                  rxreset,
	input  logic                  rx,
	input  logic                  rxp,
	input  logic                  rxm,
	input  logic                  low_speed,
	output usb_rx_pkg::rx_event_t out_evt,
	output logic                  req,
	input  logic                  ack,
	output logic                  active,
	output logic                  overrun
);

	logic                  rx_level;
	logic                  sample;
	logic                  eop;
	logic                  start;
	usb_rx_pkg::rx_event_t evt;
	logic                  evt_valid;

	////////////////////
	// Line side
	////////////////////

	usb_line_sampler i_line_sampler (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rx        (rx),
		.low_speed (low_speed),
		.rx_level  (rx_level),
		.sample    (sample)
	);

	usb_eop_detect i_eop_detect (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rxp       (rxp),
		.rxm       (rxm),
		.rx_level  (rx_level),
		.low_speed (low_speed),
		.eop       (eop)
	);

	usb_sync_detect i_sync_detect (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rx_level  (rx_level),
		.sample    (sample),
		.eop       (eop),
		.active    (active),
		.low_speed (low_speed),
		.start     (start)
	);

	////////////////////
	// Data side
	////////////////////

	usb_deserializer i_deserializer (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rx_level  (rx_level),
		.sample    (sample),
		.eop       (eop),
		.start     (start),
		.active    (active),
		.evt       (evt),
		.evt_valid (evt_valid)
	);

	usb_event_queue i_event_queue (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.evt       (evt),
		.evt_valid (evt_valid),
		.out_evt   (out_evt),
		.req       (req),
		.ack       (ack),
		.overrun   (overrun)
	);

endmodule

`default_nettype wire

//--- usb_rx_properties.sv
// USB receive handshake assertions

`timescale 1ns/10ps
`default_nettype none

module usb_rx_properties (
	input logic       usb_clk,
	input logic       rxreset,
	input logic       req,
	input logic       ack,
	input logic [9:0] out_evt,
	input logic       overrun
);

	// Four-phase rule, req waits for ack
	req_held: assert property (@(posedge usb_clk) disable iff (rxreset)
		(req && !ack) |=> req)
		else $error("req dropped before ack");

	evt_stable: assert property (@(posedge usb_clk) disable iff (rxreset)
		req |=> (!req || $stable(out_evt)))
		else $error("out_evt changed while req high");

	req_reset: assert property (@(posedge usb_clk)
		rxreset |=> !req)
		else $error("req high after rxreset");

	// Overrun is sticky
	overrun_sticky: assert property (@(posedge usb_clk)
		(overrun && !rxreset) |=> overrun)
		else $error("overrun fell without rxreset");

endmodule

bind usb_rx usb_rx_properties i_usb_rx_properties (
	.usb_clk (usb_clk),
	.rxreset (rxreset),
	.req     (req),
	.ack     (ack),
	.out_evt (out_evt),
	.overrun (overrun)
);

`default_nettype wire

//--- usb_rx_tb.sv
// USB receive path testbench

`timescale 1ns/10ps
`default_nettype none

`include "usb_rx_config.svh"

module usb_rx_tb;

	logic                  usb_clk;
	logic                  rxreset;
	logic                  rx;
	logic                  rxp;
	logic                  rxm;
	logic                  low_speed;
	logic                  ack;
	usb_rx_pkg::rx_event_t out_evt;
	logic                  req;
	logic                  active;
	logic                  overrun;

	int          errors;
	int          cycles;
	int          cycle_limit;
	int          ack_delay_max;
	logic        hold_ack;
	logic [31:0] lcg_state;
	logic [9:0]  exp_q[$];
	logic [7:0]  saved_bytes[$];
	int          saved_len[$];

	usb_rx i_usb_rx (
		.usb_clk   (usb_clk),
		.rxreset   (rxreset),
		.rx        (rx),
		.rxp       (rxp),
		.rxm       (rxm),
		.low_speed (low_speed),
		.out_evt   (out_evt),
		.req       (req),
		.ack       (ack),
		.active    (active),
		.overrun   (overrun)
	);

	initial begin
		usb_clk = 1'b0;
		forever #4 usb_clk = ~usb_clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = lcg_next();
		return lo + int'((r >> 16) % (hi - lo + 1));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Holds one line level for n cycles with J as level 1
	task automatic drive_line(input logic level, input logic se0, input int n);
		logic v;
		v = level ^ low_speed;
		repeat (n) begin
			@(negedge usb_clk);
			rx = v;
			rxp = se0 ? 1'b0 : v;
			rxm = se0 ? 1'b0 : ~v;
		end
	endtask

	// Sync, stuffed NRZI data, optional violation, then SE0 SE0 J
	task automatic send_packet(input logic [7:0] bytes[$], input int err_at,
			input int keep, output int stuffed);
		logic       sym_q[$];
		logic [9:0] evts[$];
		logic [7:0] sync;
		logic       lvl;
		logic       b;
		int         ones;
		int         bit_cycles;
		bit_cycles = low_speed ? 32 : 4;
		lvl = 1'b1;
		sync = 8'h80;
		for (int j = 0; j < 8; j++) begin
			if (!sync[j])
				lvl = ~lvl;
			sym_q.push_back(lvl);
		end
		ones = 1;
		stuffed = 0;
		for (int i = 0; i < bytes.size(); i++) begin
			if (i == err_at)
				break;
			evts.push_back({usb_rx_pkg::EVT_DATA, bytes[i]});
			for (int j = 0; j < 8; j++) begin
				b = bytes[i][j];
				if (!b)
					lvl = ~lvl;
				sym_q.push_back(lvl);
				ones = b ? ones + 1 : 0;
				if (ones == 6) begin
					lvl = ~lvl;
					sym_q.push_back(lvl);
					ones = 0;
					stuffed++;
				end
			end
		end
		if (err_at >= 0) begin
			// Seven equal line bits
			repeat (7)
				sym_q.push_back(lvl);
			evts.push_back({usb_rx_pkg::EVT_ERROR, 8'h00});
		end else begin
			evts.push_back({usb_rx_pkg::EVT_EOP, 8'h00});
		end
		for (int i = 0; i < evts.size() && i < keep; i++)
			exp_q.push_back(evts[i]);
		cycle_limit += (sym_q.size() + 3) * bit_cycles * 2;
		foreach (sym_q[i])
			drive_line(sym_q[i], 1'b0, bit_cycles);
		// rx toggles under SE0 so it decodes as zeros
		lvl = ~lvl;
		drive_line(lvl, 1'b1, bit_cycles);
		lvl = ~lvl;
		drive_line(lvl, 1'b1, bit_cycles);
		drive_line(1'b1, 1'b0, bit_cycles);
	endtask

	task automatic idle_gap();
		int n;
		n = (low_speed ? 32 : 4) * 8;
		cycle_limit += n * 2;
		drive_line(1'b1, 1'b0, n);
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge usb_clk);
		repeat (20) @(negedge usb_clk);
		check_value("req", req, 0);
	endtask

	task automatic random_packet(output logic [7:0] pkt[$]);
		int len;
		pkt.delete();
		len = rand_range(1, 8);
		repeat (len)
			pkt.push_back(8'(lcg_next() >> 16));
	endtask

	////////////////////
	// Consumer and watchdog
	////////////////////

	initial begin : consumer
		int         delay;
		logic [9:0] expv;
		forever begin
			@(negedge usb_clk);
			if (req && !hold_ack && !ack) begin
				delay = rand_range(0, ack_delay_max);
				repeat (delay) @(negedge usb_clk);
				if (exp_q.size() == 0) begin
					$display("Unexpected event %h with nothing expected", out_evt);
					errors++;
				end else begin
					expv = exp_q.pop_front();
					check_value("out_evt", out_evt, expv);
				end
				ack = 1'b1;
				while (req)
					@(negedge usb_clk);
				ack = 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
		while (cycles <= cycle_limit) begin
			@(posedge usb_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main
		logic [7:0] pkt[$];
		int         stuffed;
		int         pos;
		rxreset = 1'b1;
		rx = 1'b1;
		rxp = 1'b1;
		rxm = 1'b0;
		low_speed = 1'b0;
		ack = 1'b0;
		hold_ack = 1'b0;
		errors = 0;
		ack_delay_max = 3;
		cycle_limit = 2000;
		lcg_state = 32'hcb03;
		repeat (3) @(negedge usb_clk);
		rxreset = 1'b0;
		idle_gap();

		// Random full-speed packets
		for (int p = 0; p < 6; p++) begin
			random_packet(pkt);
			saved_len.push_back(pkt.size());
			foreach (pkt[i])
				saved_bytes.push_back(pkt[i]);
			ack_delay_max = rand_range(0, 6);
			send_packet(pkt, -1, 100, stuffed);
			idle_gap();
			wait_drain();
		end

		// Long runs of ones force stuffed bits
		pkt = '{8'hff, 8'hff, 8'hff};
		send_packet(pkt, -1, 100, stuffed);
		check_value("stuffed_bits", stuffed > 0, 1);
		idle_gap();
		wait_drain();
		pkt = '{8'h7e, 8'hff, 8'h3f, 8'hfc};
		send_packet(pkt, -1, 100, stuffed);
		check_value("stuffed_bits", stuffed > 0, 1);
		idle_gap();
		wait_drain();

		// Stuffing violations
		pkt = '{8'ha5, 8'h3c, 8'h55};
		send_packet(pkt, 2, 100, stuffed);
		idle_gap();
		wait_drain();
		send_packet(pkt, 0, 100, stuffed);
		idle_gap();
		wait_drain();

		// Same packets at low speed
		low_speed = 1'b1;
		idle_gap();
		pos = 0;
		foreach (saved_len[p]) begin
			pkt.delete();
			repeat (saved_len[p]) begin
				pkt.push_back(saved_bytes[pos]);
				pos++;
			end
			send_packet(pkt, -1, 100, stuffed);
			idle_gap();
			wait_drain();
		end
		low_speed = 1'b0;
		idle_gap();

		// Back-pressure and overrun
		hold_ack = 1'b1;
		pkt = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77};
		send_packet(pkt, -1, `USB_RX_QUEUE_DEPTH, stuffed);
		idle_gap();
		check_value("overrun", overrun, 1);
		check_value("req", req, 1);
		hold_ack = 1'b0;
		wait_drain();
		check_value("overrun", overrun, 1);

		// Reset clears the outputs before a clean packet
		rxreset = 1'b1;
		repeat (3) @(negedge usb_clk);
		rxreset = 1'b0;
		@(negedge usb_clk);
		check_value("req", req, 0);
		check_value("active", active, 0);
		check_value("overrun", overrun, 0);
		idle_gap();
		random_packet(pkt);
		send_packet(pkt, -1, 100, stuffed);
		idle_gap();
		wait_drain();

		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- usb_rx.f
+incdir+.
usb_rx_pkg.sv
usb_line_sampler.sv
usb_eop_detect.sv
usb_sync_detect.sv
usb_deserializer.sv
usb_event_queue.sv
usb_rx.sv
usb_rx_properties.sv
usb_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the USB receive path simulation with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
	-f usb_rx.f --top-module usb_rx_tb -o usb_rx_sim

./obj_dir/usb_rx_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	exit 1
fi
exit 0
